// File: fft_top.f
+incdir+rtl
rtl/fft_pkg.sv
rtl/fft_cfg_ctrl.sv
rtl/fft_input_ctrl.sv
rtl/fft_burst_core.sv
rtl/fft_output_ctrl.sv
rtl/fft_top.sv
tests/fft_checker.sv
tests/fft_tb.sv

// File: Makefile
VERILATOR := verilator
VFLAGS    := --binary --assert -Wno-fatal
TOP       := fft_tb
FILELIST  := fft_top.f
OBJDIR    := obj_dir
LOG       := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the simulation and check the log"
	@echo "  clean  remove build output and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "TESTBENCH FAILED" $(LOG); then exit 1; fi
	@grep -q "TESTBENCH PASSED" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)

// File: tests/fft_tb.sv
// Testbench top with clock, reset, random frame stimulus, timeout and final report.
`include "fft_consts.svh"

module fft_tb
    import fft_pkg::*;
;

    localparam int FWD_FRAMES = 20;
    // Three inverse frames, the short and the good frame of the early tlast test, one more.
    localparam int NUM_FRAMES = FWD_FRAMES + 6;
    localparam int CYCLE_LIMIT = NUM_FRAMES * 40 + 200;

    logic        aclk = 1'b0;
    logic        arst_n = 1'b0;
    logic        in_tvalid = 1'b0;
    logic [31:0] in_tdata = '0;
    logic        in_tlast = 1'b0;
    logic        in_tready;
    logic        cfg_tvalid = 1'b0;
    logic        cfg_tdata = 1'b0;
    logic        out_tvalid;
    logic [39:0] out_tdata;
    logic        out_tlast;
    logic [7:0]  out_tuser;
    logic [2:0]  alm;
    logic        stat;
    int          seed = 32'h858a85e9;
    int          cycle = 0;
    int          tests_run = 0;
    int          tests_failed = 0;
    int          errs_before;

    always #5 aclk = ~aclk;

    fft_top i_fft_top (
        .i_aclk              (aclk),
        .i_arst_n            (arst_n),
        .i_axi4s_data_tvalid (in_tvalid),
        .i_axi4s_data_tdata  (in_tdata),
        .i_axi4s_data_tlast  (in_tlast),
        .o_axi4s_data_tready (in_tready),
        .i_axi4s_cfg_tvalid  (cfg_tvalid),
        .i_axi4s_cfg_tdata   (cfg_tdata),
        .o_axi4s_data_tvalid (out_tvalid),
        .o_axi4s_data_tdata  (out_tdata),
        .o_axi4s_data_tlast  (out_tlast),
        .o_axi4s_data_tuser  (out_tuser),
        .o_alm               (alm),
        .o_stat              (stat)
    );

    fft_checker i_checker (
        .i_aclk       (aclk),
        .i_arst_n     (arst_n),
        .i_tvalid     (in_tvalid),
        .i_tdata      (in_tdata),
        .i_tlast      (in_tlast),
        .i_tready     (in_tready),
        .i_out_tvalid (out_tvalid),
        .i_out_tdata  (out_tdata),
        .i_out_tlast  (out_tlast),
        .i_out_tuser  (out_tuser),
        .i_alm        (alm),
        .i_stat       (stat)
    );

    always @(posedge aclk) begin
        cycle <= cycle + 1;
        if (cycle >= CYCLE_LIMIT) begin
            $display("Timeout: run exceeded %0d cycles", CYCLE_LIMIT);
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    // All stimulus changes 1 time unit after a rising edge.
    task automatic next_cycle();
        @(posedge aclk);
        #1;
    endtask

    task automatic drive_beat(input logic [31:0] data, input logic last);
        while (!in_tready) next_cycle();
        in_tvalid = 1'b1;
        in_tdata  = data;
        in_tlast  = last;
        next_cycle();
        in_tvalid = 1'b0;
        in_tlast  = 1'b0;
    endtask

    task automatic send_beats(input int count, input bit last_at_end);
        for (int i = 0; i < count; i++) begin
            drive_beat($random(seed), last_at_end && i == count - 1);
        end
    endtask

    task automatic strobe_cfg(input logic inverse);
        cfg_tvalid = 1'b1;
        cfg_tdata  = inverse;
        next_cycle();
        cfg_tvalid = 1'b0;
    endtask

    task automatic wait_frame_done();
        next_cycle();
        while (i_checker.pending || !in_tready) next_cycle();
        repeat (2) next_cycle();
    endtask

    task automatic start_test();
        errs_before = i_checker.errors;
    endtask

    task automatic end_test(input string name);
        tests_run++;
        if (i_checker.errors == errs_before) begin
            $display("Test %0d %s: ok", tests_run, name);
        end else begin
            tests_failed++;
            $display("Test %0d %s: %0d errors", tests_run, name,
                     i_checker.errors - errs_before);
        end
    endtask

    initial begin
        repeat (5) @(posedge aclk);
        #1;
        arst_n = 1'b1;

        start_test();
        if (out_tvalid !== 1'b0) i_checker.mismatch("o_axi4s_data_tvalid", 0, out_tvalid);
        if (out_tlast !== 1'b0) i_checker.mismatch("o_axi4s_data_tlast", 0, out_tlast);
        if (alm !== 3'b000) i_checker.mismatch("o_alm", 0, alm);
        if (stat !== 1'b0) i_checker.mismatch("o_stat", 0, stat);
        if (in_tready !== 1'b1) i_checker.mismatch("o_axi4s_data_tready", 1, in_tready);
        end_test("reset state");

        start_test();
        for (int f = 0; f < FWD_FRAMES; f++) begin
            i_checker.expect_frame(FFT_FWD);
            send_beats(8, 1);
            wait_frame_done();
        end
        end_test("forward frames with timing");

        start_test();
        strobe_cfg(1'b1);
        i_checker.expect_frame(FFT_INV);
        send_beats(8, 1);
        wait_frame_done();
        // The strobe lands after the first beat, so this frame stays inverse.
        i_checker.expect_frame(FFT_INV);
        send_beats(3, 0);
        strobe_cfg(1'b0);
        send_beats(5, 1);
        wait_frame_done();
        i_checker.expect_frame(FFT_INV);
        send_beats(8, 1);
        wait_frame_done();
        strobe_cfg(1'b0);
        end_test("inverse frames and mode hold");

        start_test();
        send_beats(3, 1);
        repeat (30) next_cycle();
        i_checker.expect_frame(FFT_FWD);
        send_beats(8, 1);
        wait_frame_done();
        end_test("early tlast");

        start_test();
        i_checker.expect_frame(FFT_FWD);
        send_beats(8, 0);
        in_tvalid = 1'b1;
        for (int i = 0; i < 3; i++) begin
            in_tdata = $random(seed);
            next_cycle();
        end
        in_tvalid = 1'b0;
        wait_frame_done();
        end_test("missing tlast and input while not ready");

        $display("Summary: %0d tests, %0d failed, %0d frames checked, %0d errors",
                 tests_run, tests_failed, i_checker.frames_done, i_checker.errors);
        if (i_checker.errors == 0 && tests_failed == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

// File: tests/fft_checker.sv
// Reference FFT model, framing and alarm model, and comparison against the DUT ports.
`include "fft_consts.svh"

module fft_checker
    import fft_pkg::*;
(
    input logic        i_aclk,
    input logic        i_arst_n,
    input logic        i_tvalid,
    input logic [31:0] i_tdata,
    input logic        i_tlast,
    input logic        i_tready,
    input logic        i_out_tvalid,
    input logic [39:0] i_out_tdata,
    input logic        i_out_tlast,
    input logic [7:0]  i_out_tuser,
    input logic [2:0]  i_alm,
    input logic        i_stat
);

    // Edges from the eighth accepted beat to the first output beat, 14 full cycles between.
    localparam int OUT_LATENCY = 15;

    int        errors = 0;
    int        frames_done = 0;
    bit        pending = 0;
    fft_mode_e mode_q[$];
    int        cap_re[8];
    int        cap_im[8];
    int        exp_re[8];
    int        exp_im[8];
    int        beat_cnt;
    int        out_idx;
    int        lat_cnt;
    logic [2:0] alm_exp;
    logic      stat_exp;

    function automatic void expect_frame(input fft_mode_e m);
        mode_q.push_back(m);
    endfunction

    function automatic void mismatch(input string name, input longint exp_v, input longint act_v);
        $display("Mismatch at %0t: %s expected %0d, got %0d", $time, name, exp_v, act_v);
        errors++;
    endfunction

    function automatic void problem(input string what);
        $display("Error at %0t: %s", $time, what);
        errors++;
    endfunction

    function automatic int bit_reverse(input int n);
        return ((n & 1) << 2) | (n & 2) | ((n >> 2) & 1);
    endfunction

    // Decimation in time, unscaled, Q15 twiddles with round half up.
    task automatic run_model(input bit inv);
        int ar[8];
        int ai[8];
        int h;
        int j;
        int t;
        int p;
        int q;
        int k;
        int wr;
        int wi;
        int tr;
        int ti;
        int a_re;
        int a_im;
        for (int n = 0; n < 8; n++) begin
            ar[bit_reverse(n)] = cap_re[n];
            ai[bit_reverse(n)] = cap_im[n];
        end
        for (h = 1; h < 8; h = h * 2) begin
            for (j = 0; j < 8; j = j + 2 * h) begin
                for (t = 0; t < h; t++) begin
                    p = j + t;
                    q = p + h;
                    k = t * (8 / (2 * h));
                    if (k == 0) begin
                        tr = ar[q];
                        ti = ai[q];
                    end else if (k == 2) begin
                        tr = inv ? -ai[q] : ai[q];
                        ti = inv ? ar[q] : -ar[q];
                    end else begin
                        wr = (k == 1) ? `TW_C45 : -`TW_C45;
                        wi = inv ? `TW_C45 : -`TW_C45;
                        tr = int'((longint'(ar[q]) * wr - longint'(ai[q]) * wi + 16384) >>> 15);
                        ti = int'((longint'(ar[q]) * wi + longint'(ai[q]) * wr + 16384) >>> 15);
                    end
                    a_re = ar[p];
                    a_im = ai[p];
                    ar[p] = a_re + tr;
                    ai[p] = a_im + ti;
                    ar[q] = a_re - tr;
                    ai[q] = a_im - ti;
                end
            end
        end
        exp_re = ar;
        exp_im = ai;
    endtask

    always @(posedge i_aclk) begin
        logic       accept;
        logic       early;
        logic       end_now;
        logic [2:0] alm_next;
        int         act_re;
        int         act_im;
        if (!i_arst_n) begin
            beat_cnt = 0;
            out_idx  = 0;
            pending  = 0;
            alm_exp  = 3'b000;
            stat_exp = 1'b0;
        end else begin
            accept   = i_tvalid && i_tready;
            early    = accept && i_tlast && beat_cnt != 7;
            end_now  = i_out_tvalid && i_out_tuser[2:0] == 3'd6;
            alm_next = {i_tvalid && !i_tready, accept && beat_cnt == 7 && !i_tlast, early};
            if (i_alm !== alm_exp) mismatch("o_alm", alm_exp, i_alm);
            if (i_stat !== stat_exp) mismatch("o_stat", stat_exp, i_stat);
            if (i_out_tlast && !i_out_tvalid) problem("tlast high without tvalid");

            // ~~~~~~~~~~~~~~~~~~~~
            // Output side
            // ~~~~~~~~~~~~~~~~~~~~
            if (pending) begin
                lat_cnt++;
                if (!i_out_tlast && i_tready) problem("tready high while a frame is in flight");
                if (i_out_tlast && !i_tready) problem("tready still low after the last output beat");
                if (out_idx > 0 && !i_out_tvalid) problem("gap inside the output frame");
            end
            if (i_out_tvalid) begin
                if (!pending) begin
                    problem("output beat without a frame in flight");
                end else begin
                    if (out_idx == 0 && lat_cnt != OUT_LATENCY)
                        mismatch("latency", OUT_LATENCY, lat_cnt);
                    act_re = int'($signed(i_out_tdata[19:0]));
                    act_im = int'($signed(i_out_tdata[39:20]));
                    if (i_out_tuser !== 8'(out_idx))
                        mismatch("o_axi4s_data_tuser", out_idx, i_out_tuser);
                    if (act_re != exp_re[out_idx]) mismatch("bin re", exp_re[out_idx], act_re);
                    if (act_im != exp_im[out_idx]) mismatch("bin im", exp_im[out_idx], act_im);
                    if (i_out_tlast !== (out_idx == 7))
                        mismatch("o_axi4s_data_tlast", out_idx == 7, i_out_tlast);
                    out_idx++;
                    if (out_idx == 8) begin
                        pending = 0;
                        out_idx = 0;
                        frames_done++;
                    end
                end
            end

            // ~~~~~~~~~~~~~~~~~~~~
            // Input side
            // ~~~~~~~~~~~~~~~~~~~~
            if (early) begin
                beat_cnt = 0;
            end else if (accept) begin
                cap_re[beat_cnt] = int'($signed(i_tdata[15:0]));
                cap_im[beat_cnt] = int'($signed(i_tdata[31:16]));
                if (beat_cnt == 7) begin
                    beat_cnt = 0;
                    if (mode_q.size() == 0) begin
                        problem("frame completed that the testbench did not announce");
                    end else begin
                        run_model(mode_q.pop_front() == FFT_INV);
                        pending = 1;
                        lat_cnt = 0;
                    end
                end else begin
                    beat_cnt++;
                end
            end
            alm_exp  = alm_next;
            stat_exp = (early || end_now) ? 1'b0 : (accept ? 1'b1 : stat_exp);
        end
    end

endmodule

// File: rtl/fft_top.sv
// Top level of the 8-point burst FFT with configuration, input, core and output blocks.
`include "fft_consts.svh"

module fft_top
    import fft_pkg::*;
(
    input  logic                      i_aclk,
    input  logic                      i_arst_n,

    input  logic                      i_axi4s_data_tvalid,
    input  logic [2*`IN_WIDTH-1:0]    i_axi4s_data_tdata,
    input  logic                      i_axi4s_data_tlast,
    output logic                      o_axi4s_data_tready,

    input  logic                      i_axi4s_cfg_tvalid,
    input  logic                      i_axi4s_cfg_tdata,

    output logic                      o_axi4s_data_tvalid,
    output logic [2*`OUT_WIDTH-1:0]   o_axi4s_data_tdata,
    output logic                      o_axi4s_data_tlast,
    output logic [7:0]                o_axi4s_data_tuser,

    output logic [2:0]                o_alm,
    output logic                      o_stat
);

    fft_mode_e fft_mode;
    xn_beat_t  xn;
    xk_beat_t  xk;
    logic      fft_end;

    fft_cfg_ctrl u_cfg_ctrl (
        .i_aclk          (i_aclk),
        .i_arst_n        (i_arst_n),
        .i_cfg_vld       (i_axi4s_cfg_tvalid),
        .i_cfg_data      (i_axi4s_cfg_tdata),
        .i_frame_started (o_stat),
        .o_fft_mode      (fft_mode)
    );

    fft_input_ctrl u_input_ctrl (
        .i_aclk        (i_aclk),
        .i_arst_n      (i_arst_n),
        .i_datain      (i_axi4s_data_tdata),
        .i_datain_vld  (i_axi4s_data_tvalid),
        .i_datain_last (i_axi4s_data_tlast),
        .i_fft_end     (fft_end),
        .o_datain_rdy  (o_axi4s_data_tready),
        .o_xn          (xn),
        .o_input_alm   (o_alm),
        .o_input_stat  (o_stat)
    );

    fft_burst_core u_burst_core (
        .i_aclk     (i_aclk),
        .i_arst_n   (i_arst_n),
        .i_xn       (xn),
        .i_fft_mode (fft_mode),
        .o_fft_end  (fft_end),
        .o_xk       (xk)
    );

    fft_output_ctrl u_output_ctrl (
        .i_aclk         (i_aclk),
        .i_arst_n       (i_arst_n),
        .i_xk           (xk),
        .o_dataout      (o_axi4s_data_tdata),
        .o_dataout_vld  (o_axi4s_data_tvalid),
        .o_dataout_last (o_axi4s_data_tlast),
        .o_dataout_usr  (o_axi4s_data_tuser)
    );

endmodule

// File: rtl/fft_output_ctrl.sv
// Registered output stream with tlast and the bin index in tuser.
`include "fft_consts.svh"

module fft_output_ctrl
    import fft_pkg::*;
(
    input  logic                      i_aclk,
    input  logic                      i_arst_n,
    input  xk_beat_t                  i_xk,
    output logic [2*`OUT_WIDTH-1:0]   o_dataout,
    output logic                      o_dataout_vld,
    output logic                      o_dataout_last,
    output logic [7:0]                o_dataout_usr
);

    always_ff @(posedge i_aclk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_dataout_vld  <= 1'b0;
            o_dataout_last <= 1'b0;
        end else begin
            o_dataout_vld  <= i_xk.valid;
            o_dataout_last <= i_xk.valid && i_xk.last;
        end
    end

    // im lands in the upper half because of the struct order.
    always_ff @(posedge i_aclk) begin
        if (i_xk.valid) begin
            o_dataout     <= i_xk.bin;
            o_dataout_usr <= {{(8 - `LOG2_FFT_LEN){1'b0}}, i_xk.index};
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // Assertions
    // ~~~~~~~~~~~~~~~~~~~~
    property p_last_with_valid;
        @(posedge i_aclk) disable iff (!i_arst_n)
        o_dataout_last |-> o_dataout_vld && o_dataout_usr[`LOG2_FFT_LEN-1:0] == '1;
    endproperty

    a_last_with_valid: assert property (p_last_with_valid)
        else $error("fft_output_ctrl: tlast without tvalid or not on the last bin");

endmodule

// File: rtl/fft_burst_core.sv
// In-place radix-2 burst FFT core with sample memory, butterfly sequencer and readout.
`include "fft_consts.svh"

module fft_burst_core
    import fft_pkg::*;
(
    input  logic      i_aclk,
    input  logic      i_arst_n,
    input  xn_beat_t  i_xn,
    input  fft_mode_e i_fft_mode,
    output logic      o_fft_end,
    output xk_beat_t  o_xk
);

    cplx_out_t                      mem [`FFT_LEN];
    core_state_e                    state;
    logic [1:0]                     stage;
    logic [`LOG2_FFT_LEN-2:0]       bfly;
    logic [`LOG2_FFT_LEN-1:0]       rd_cnt;
    logic [`LOG2_FFT_LEN-1:0]       addr_a;
    logic [`LOG2_FFT_LEN-1:0]       addr_b;
    logic [`LOG2_FFT_LEN-2:0]       tw_k;
    logic signed [`TW_WIDTH-1:0]    tw_re;
    logic signed [`TW_WIDTH-1:0]    tw_im;
    logic signed [`OUT_WIDTH+`TW_WIDTH:0] prod_re;
    logic signed [`OUT_WIDTH+`TW_WIDTH:0] prod_im;
    cplx_out_t                      op_a;
    cplx_out_t                      op_b;
    cplx_out_t                      bw;
    cplx_out_t                      sum;
    cplx_out_t                      diff;
    cplx_out_t                      xn_ext;
    logic                           inv;

    assign inv = (i_fft_mode == FFT_INV);

    // ~~~~~~~~~~~~~~~~~~~~
    // Sequencer
    // ~~~~~~~~~~~~~~~~~~~~
    // Address 7 holds the eighth sample only, so its write closes the frame.
    always_ff @(posedge i_aclk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            state  <= CORE_LOAD;
            stage  <= 2'd0;
            bfly   <= '0;
            rd_cnt <= '0;
        end else begin
            case (state)
                CORE_LOAD: begin
                    if (i_xn.valid && i_xn.index == `LOG2_FFT_LEN'(`FFT_LEN - 1)) begin
                        state <= CORE_CALC;
                        stage <= 2'd0;
                        bfly  <= '0;
                    end
                end
                CORE_CALC: begin
                    bfly <= bfly + 1'b1;
                    if (bfly == '1) begin
                        stage <= stage + 1'b1;
                        if (stage == 2'(`LOG2_FFT_LEN - 1)) begin
                            state  <= CORE_DRAIN;
                            rd_cnt <= '0;
                        end
                    end
                end
                CORE_DRAIN: begin
                    rd_cnt <= rd_cnt + 1'b1;
                    if (rd_cnt == `LOG2_FFT_LEN'(`FFT_LEN - 1)) begin
                        state <= CORE_LOAD;
                    end
                end
                default: state <= CORE_LOAD;
            endcase
        end
    end

    // Butterfly pair and twiddle exponent for each stage of the decimation in time.
    always_comb begin
        case (stage)
            2'd0: begin
                addr_a = {bfly, 1'b0};
                addr_b = {bfly, 1'b1};
                tw_k   = 2'd0;
            end
            2'd1: begin
                addr_a = {bfly[1], 1'b0, bfly[0]};
                addr_b = {bfly[1], 1'b1, bfly[0]};
                tw_k   = {bfly[0], 1'b0};
            end
            default: begin
                addr_a = {1'b0, bfly};
                addr_b = {1'b1, bfly};
                tw_k   = bfly;
            end
        endcase
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // Butterfly
    // ~~~~~~~~~~~~~~~~~~~~
    // Only W8^1 and W8^3 need the multiplier; the inverse uses the conjugate.
    always_comb begin
        tw_re = '0;
        tw_im = '0;
        case (tw_k)
            2'd1: begin
                tw_re = `TW_C45;
                tw_im = inv ? `TW_C45 : -`TW_C45;
            end
            2'd3: begin
                tw_re = -`TW_C45;
                tw_im = inv ? `TW_C45 : -`TW_C45;
            end
            default: ;
        endcase
    end

    always_comb begin
        op_a    = mem[addr_a];
        op_b    = mem[addr_b];
        prod_re = op_b.re * tw_re - op_b.im * tw_im;
        prod_im = op_b.re * tw_im + op_b.im * tw_re;
        prod_re = (prod_re + `TW_RND) >>> `TW_FRAC;
        prod_im = (prod_im + `TW_RND) >>> `TW_FRAC;
        case (tw_k)
            2'd0: bw = op_b;
            2'd2: begin
                // Times -j forward, +j inverse.
                bw.re = inv ? -op_b.im : op_b.im;
                bw.im = inv ? op_b.re : -op_b.re;
            end
            default: begin
                bw.re = prod_re[`OUT_WIDTH-1:0];
                bw.im = prod_im[`OUT_WIDTH-1:0];
            end
        endcase
        sum.re  = op_a.re + bw.re;
        sum.im  = op_a.im + bw.im;
        diff.re = op_a.re - bw.re;
        diff.im = op_a.im - bw.im;
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // Sample memory
    // ~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        xn_ext.re = {{(`OUT_WIDTH - `IN_WIDTH){i_xn.sample.re[`IN_WIDTH-1]}}, i_xn.sample.re};
        xn_ext.im = {{(`OUT_WIDTH - `IN_WIDTH){i_xn.sample.im[`IN_WIDTH-1]}}, i_xn.sample.im};
    end

    always_ff @(posedge i_aclk) begin
        if (state == CORE_LOAD && i_xn.valid) begin
            mem[i_xn.index] <= xn_ext;
        end else if (state == CORE_CALC) begin
            mem[addr_a] <= sum;
            mem[addr_b] <= diff;
        end
    end

    // Bins leave in natural order straight from memory.
    always_comb begin
        o_xk.bin   = mem[rd_cnt];
        o_xk.index = rd_cnt;
        o_xk.valid = (state == CORE_DRAIN);
        o_xk.last  = (state == CORE_DRAIN) && (rd_cnt == `LOG2_FFT_LEN'(`FFT_LEN - 1));
        o_fft_end  = o_xk.last;
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // Assertions
    // ~~~~~~~~~~~~~~~~~~~~
    property p_input_only_in_load;
        @(posedge i_aclk) disable iff (!i_arst_n)
        i_xn.valid |-> state == CORE_LOAD;
    endproperty

    a_input_only_in_load: assert property (p_input_only_in_load)
        else $error("fft_burst_core: sample arrived during calculation or readout");

    property p_end_is_pulse;
        @(posedge i_aclk) disable iff (!i_arst_n)
        o_fft_end |=> !o_fft_end;
    endproperty

    a_end_is_pulse: assert property (p_end_is_pulse)
        else $error("fft_burst_core: fft_end longer than one cycle");

endmodule

// File: rtl/fft_input_ctrl.sv
// Input framing with bit-reversed addressing, tready, framing alarms and frame status.
`include "fft_consts.svh"

module fft_input_ctrl
    import fft_pkg::*;
(
    input  logic        i_aclk,
    input  logic        i_arst_n,
    input  logic [31:0] i_datain,
    input  logic        i_datain_vld,
    input  logic        i_datain_last,
    input  logic        i_fft_end,
    output logic        o_datain_rdy,
    output xn_beat_t    o_xn,
    output logic [2:0]  o_input_alm,
    output logic        o_input_stat
);

    logic [`LOG2_FFT_LEN-1:0] beat_cnt;
    logic                     accept;
    logic                     last_beat;
    logic                     early_last;
    cplx_in_t                 xn_sample;
    logic [`LOG2_FFT_LEN-1:0] xn_index;
    logic                     xn_vld;

    assign accept     = i_datain_vld && o_datain_rdy;
    assign last_beat  = (beat_cnt == `LOG2_FFT_LEN'(`FFT_LEN - 1));
    assign early_last = accept && i_datain_last && !last_beat;

    // ~~~~~~~~~~~~~~~~~~~~
    // Framing
    // ~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge i_aclk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            beat_cnt     <= '0;
            o_datain_rdy <= 1'b1;
            o_input_stat <= 1'b0;
            o_input_alm  <= 3'b000;
            xn_vld       <= 1'b0;
        end else begin
            o_input_alm[0] <= early_last;
            o_input_alm[1] <= accept && last_beat && !i_datain_last;
            o_input_alm[2] <= i_datain_vld && !o_datain_rdy;
            // A short frame is dropped. The next frame overwrites its partial samples.
            xn_vld         <= accept && !early_last;

            if (early_last) begin
                beat_cnt <= '0;
            end else if (accept) begin
                beat_cnt <= beat_cnt + 1'b1;
            end

            if (accept && last_beat) begin
                o_datain_rdy <= 1'b0;
            end else if (i_fft_end) begin
                o_datain_rdy <= 1'b1;
            end

            if (early_last || i_fft_end) begin
                o_input_stat <= 1'b0;
            end else if (accept) begin
                o_input_stat <= 1'b1;
            end
        end
    end

    // Sample and its memory address, bits of the beat count reversed.
    always_ff @(posedge i_aclk) begin
        if (accept) begin
            xn_sample <= cplx_in_t'(i_datain);
            xn_index  <= {beat_cnt[0], beat_cnt[1], beat_cnt[2]};
        end
    end

    always_comb begin
        o_xn.sample = xn_sample;
        o_xn.index  = xn_index;
        o_xn.valid  = xn_vld;
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // Assertions
    // ~~~~~~~~~~~~~~~~~~~~

    // While tready is low, the only beat handed to the core is the one that closed the frame.
    property p_beat_needs_ready;
        @(posedge i_aclk) disable iff (!i_arst_n)
        o_xn.valid && !o_datain_rdy |-> o_xn.index == '1;
    endproperty

    a_beat_needs_ready: assert property (p_beat_needs_ready)
        else $error("fft_input_ctrl: beat emitted while tready was low");

endmodule

// File: rtl/fft_cfg_ctrl.sv
// Transform direction register, updated by the configuration strobe between frames.
module fft_cfg_ctrl
    import fft_pkg::*;
(
    input  logic      i_aclk,
    input  logic      i_arst_n,
    input  logic      i_cfg_vld,
    input  logic      i_cfg_data,
    input  logic      i_frame_started,
    output fft_mode_e o_fft_mode
);

    // A strobe that lands while a frame is being collected or transformed is dropped.
    always_ff @(posedge i_aclk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_fft_mode <= FFT_FWD;
        end else if (i_cfg_vld && !i_frame_started) begin
            o_fft_mode <= i_cfg_data ? FFT_INV : FFT_FWD;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // Assertions
    // ~~~~~~~~~~~~~~~~~~~~

    // The frame status comes from the input controller, so this covers the whole frame.
    property p_mode_stable_in_frame;
        @(posedge i_aclk) disable iff (!i_arst_n)
        i_frame_started |=> $stable(o_fft_mode);
    endproperty

    a_mode_stable_in_frame: assert property (p_mode_stable_in_frame)
        else $error("fft_cfg_ctrl: mode changed during a frame");

endmodule

// File: rtl/fft_pkg.sv
// Sample structs, stream beat structs, transform mode and core state types.
`include "fft_consts.svh"

package fft_pkg;

    typedef enum logic {
        FFT_FWD = 1'b0,
        FFT_INV = 1'b1
    } fft_mode_e;

    typedef enum logic [1:0] {
        CORE_LOAD,
        CORE_CALC,
        CORE_DRAIN
    } core_state_e;

    // Imaginary part sits in the upper half, as on the stream.
    typedef struct packed {
        logic signed [`IN_WIDTH-1:0] im;
        logic signed [`IN_WIDTH-1:0] re;
    } cplx_in_t;

    typedef struct packed {
        logic signed [`OUT_WIDTH-1:0] im;
        logic signed [`OUT_WIDTH-1:0] re;
    } cplx_out_t;

    typedef struct packed {
        cplx_in_t                  sample;
        logic [`LOG2_FFT_LEN-1:0]  index;
        logic                      valid;
    } xn_beat_t;

    typedef struct packed {
        cplx_out_t                 bin;
        logic [`LOG2_FFT_LEN-1:0]  index;
        logic                      valid;
        logic                      last;
    } xk_beat_t;

endpackage

// File: rtl/fft_consts.svh
// Transform length, sample and twiddle widths, and twiddle constants for the 8-point FFT.
`ifndef FFT_CONSTS_SVH
`define FFT_CONSTS_SVH

// ~~~~~~~~~~~~~~~~~~~~
// Transform size
// ~~~~~~~~~~~~~~~~~~~~
`define FFT_LEN       8
`define LOG2_FFT_LEN  3

// ~~~~~~~~~~~~~~~~~~~~
// Sample widths
// ~~~~~~~~~~~~~~~~~~~~
// Unscaled output grows by log2 of the length plus one bit for the complex sum.
`define IN_WIDTH      16
`define OUT_WIDTH     20

// ~~~~~~~~~~~~~~~~~~~~
// Twiddles, Q15
// ~~~~~~~~~~~~~~~~~~~~
`define TW_WIDTH      16
`define TW_C45        23170
`define TW_FRAC       15
`define TW_RND        16384

`endif
